/* daq_tx_pkg.sv */
`default_nettype none

package daq_tx_pkg;

	localparam int WORD_W = 16;
	localparam int K_W    = 2;	// One flag per octet, bit 0 is the low octet

	////////////////////////////////////////
	// Octet codes
	////////////////////////////////////////
	localparam logic [7:0] K28_5    = 8'hBC;
	localparam logic [7:0] D16_2    = 8'h50;
	localparam logic [7:0] K27_7    = 8'hFB;	// /S/ Start of Packet
	localparam logic [7:0] K29_7    = 8'hFD;	// /T/ End of Packet
	localparam logic [7:0] K23_7    = 8'hF7;	// /R/ Carrier extend
	localparam logic [7:0] PRMBL    = 8'h55;
	localparam logic [7:0] SOF_BYTE = 8'hD5;

	// Frame words, high octet on the left
	localparam logic [WORD_W-1:0] IDLE2    = {D16_2, K28_5};	// K 01
	localparam logic [WORD_W-1:0] SOP_PRE  = {PRMBL, K27_7};	// K 01
	localparam logic [WORD_W-1:0] PREAMBLE = {PRMBL, PRMBL};	// K 00
	localparam logic [WORD_W-1:0] SOF_PRE  = {SOF_BYTE, PRMBL};	// K 00
	localparam logic [WORD_W-1:0] EOP_EXT  = {K23_7, K29_7};	// K 11
	localparam logic [WORD_W-1:0] CAR_EXT  = {K23_7, K23_7};	// K 11

	// Frame ROM index
	typedef enum logic [2:0]
	{
		ROM_IDLE = 3'd0,
		ROM_SOP  = 3'd1,
		ROM_PRE  = 3'd2,
		ROM_SOF  = 3'd3,
		ROM_FILL = 3'd4,
		ROM_EOP  = 3'd5,
		ROM_EXT  = 3'd6
	} rom_addr_t;

	// Output word, built per octet and sent whole
	typedef union packed
	{
		logic [WORD_W-1:0] word;
		struct packed
		{
			logic [7:0] hi_oct;
			logic [7:0] lo_oct;
		} oct;
	} tx_word_u;

	// Ethernet CRC-32, reflected form
	localparam logic [31:0] CRC_POLY = 32'hEDB88320;
	localparam logic [31:0] CRC_INIT = 32'hFFFFFFFF;

	localparam int                   PKT_LEN_W   = 10;
	localparam logic [PKT_LEN_W-1:0] PKT_LEN_RST = 10'd800;

endpackage

`default_nettype wire

/* daq_crc_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface daq_crc_if;
	import daq_tx_pkg::*;

	logic              init;	// Reload CRC_INIT
	logic              calc;	// Fold data on this edge
	logic [WORD_W-1:0] data;
	logic [31:0]       crc;	// Complemented remainder

	modport pipe
	(
		output init,
		output calc,
		output data,
		input  crc
	);

	modport engine
	(
		input  init,
		input  calc,
		input  data,
		output crc
	);

endinterface

`default_nettype wire

/* daq_rst_sync.sv */
`timescale 1ns/1ps
`default_nettype none

module daq_rst_sync #(
	parameter int RST_STAGES = 4
)
(
	input  wire  usr_clk_wordwise,
	input  wire  arst,
	input  wire  pll_lock_i,
	output logic word_rst_o
);

	logic [RST_STAGES-1:0] rst_sr;

	// Preset on arst, then drains zeros only while the PLL holds lock
	always_ff @(posedge usr_clk_wordwise or posedge arst)
	begin
		if (arst)
			rst_sr <= '1;
		else if (pll_lock_i)
			rst_sr <= {rst_sr[RST_STAGES-2:0], 1'b0};
	end

	assign word_rst_o = rst_sr[RST_STAGES-1];	// Released RST_STAGES clocks after lock

endmodule

`default_nettype wire

/* daq_crc32.sv */
`timescale 1ns/1ps
`default_nettype none

module daq_crc32
(
	input wire        usr_clk_wordwise,
	input wire        arst,
	daq_crc_if.engine crc_if
);
	import daq_tx_pkg::*;

	logic [31:0] crc_r;	// Running remainder

	// Bit serial reflected update unrolled over one word
	// Index 0 first, so the low octet goes ahead of the high octet
	function automatic logic [31:0] crc_fold
	(
		input logic [31:0]       crc_in,
		input logic [WORD_W-1:0] data
	);
		logic [31:0] acc;
		acc = crc_in;
		for (int i = 0; i < WORD_W; i++)
		begin
			if (acc[0] ^ data[i])
				acc = (acc >> 1) ^ CRC_POLY;
			else
				acc = acc >> 1;
		end
		return acc;
	endfunction

	////////////////////////////////////////
	// Remainder register
	////////////////////////////////////////
	always_ff @(posedge usr_clk_wordwise or posedge arst)
	begin
		if (arst)
			crc_r <= CRC_INIT;
		else if (crc_if.init)
			crc_r <= CRC_INIT;	// Start of a new frame
		else if (crc_if.calc)
			crc_r <= crc_fold(crc_r, crc_if.data);
	end

	// FCS goes out inverted
	assign crc_if.crc = ~crc_r;

endmodule

`default_nettype wire

/* daq_frame_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module daq_frame_fsm #(
	parameter int IPG_WORDS = 6
)
(
	input  wire                   usr_clk_wordwise,
	input  wire                   arst,
	input  wire                   word_rst_i,
	input  wire                   txd_vld_i,
	output logic                  tx_ack_o,
	output daq_tx_pkg::rom_addr_t rom_addr_o,
	output logic                  crc_dv_o,
	output logic                  clr_crc_o
);
	import daq_tx_pkg::*;

	localparam int GAP_W = (IPG_WORDS > 1) ? $clog2(IPG_WORDS) : 1;

	// State codes
	localparam logic [3:0] ST_IDLE = 4'd0;
	localparam logic [3:0] ST_SOP  = 4'd1;
	localparam logic [3:0] ST_PRE1 = 4'd2;
	localparam logic [3:0] ST_PRE2 = 4'd3;
	localparam logic [3:0] ST_SOF  = 4'd4;
	localparam logic [3:0] ST_DATA = 4'd5;
	localparam logic [3:0] ST_CRC1 = 4'd6;
	localparam logic [3:0] ST_CRC2 = 4'd7;
	localparam logic [3:0] ST_EOP  = 4'd8;
	localparam logic [3:0] ST_EXT  = 4'd9;
	localparam logic [3:0] ST_GAP  = 4'd10;

	logic [3:0]       state;
	logic [3:0]       state_nxt;
	logic [GAP_W-1:0] gap_cnt;	// Inter packet gap words left

	////////////////////////////////////////
	// State register and next state
	////////////////////////////////////////
	always_ff @(posedge usr_clk_wordwise or posedge arst)
	begin
		if (arst)
			state <= ST_IDLE;
		else
			state <= state_nxt;
	end

	always_comb
	begin
		state_nxt = state;
		case (state)
			ST_IDLE:
				if (txd_vld_i)
					state_nxt = ST_SOP;
			ST_SOP:  state_nxt = ST_PRE1;
			ST_PRE1: state_nxt = ST_PRE2;
			ST_PRE2: state_nxt = ST_SOF;
			ST_SOF:  state_nxt = ST_DATA;
			ST_DATA:
				if (!txd_vld_i)
					state_nxt = ST_CRC1;	// First cycle with valid low
			ST_CRC1: state_nxt = ST_CRC2;
			ST_CRC2: state_nxt = ST_EOP;
			ST_EOP:  state_nxt = ST_EXT;
			ST_EXT:  state_nxt = ST_GAP;
			ST_GAP:
				if (gap_cnt == '0)
					state_nxt = ST_IDLE;
			default: state_nxt = ST_IDLE;
		endcase
		if (word_rst_i)
			state_nxt = ST_IDLE;	// Park until the word reset clears
	end

	always_ff @(posedge usr_clk_wordwise or posedge arst)
	begin
		if (arst)
			gap_cnt <= '0;
		else if (state == ST_EXT)
			gap_cnt <= GAP_W'(IPG_WORDS - 1);
		else if (gap_cnt != '0)
			gap_cnt <= gap_cnt - 1'b1;
	end

	////////////////////////////////////////
	// ROM address
	////////////////////////////////////////
	// DATA keeps the cycle in which valid drops, so the two CRC words take
	// the output slots of DATA and CRC1. From CRC2 on each state launches
	// the word that follows in the frame.
	always_comb
	begin
		case (state)
			ST_SOP:  rom_addr_o = ROM_SOP;
			ST_PRE1: rom_addr_o = ROM_PRE;
			ST_PRE2: rom_addr_o = ROM_PRE;
			ST_SOF:  rom_addr_o = ROM_SOF;
			ST_DATA: rom_addr_o = ROM_FILL;
			ST_CRC1: rom_addr_o = ROM_FILL;	// K flag for the CRC high half
			ST_CRC2: rom_addr_o = ROM_EOP;
			ST_EOP:  rom_addr_o = ROM_EXT;
			default: rom_addr_o = ROM_IDLE;	// EXT, GAP and IDLE
		endcase
	end

	assign tx_ack_o  = (state == ST_SOF);	// User starts data next cycle
	assign clr_crc_o = (state == ST_SOF);
	assign crc_dv_o  = (state == ST_DATA);

endmodule

`default_nettype wire

/* daq_frame_mux.sv */
`timescale 1ns/1ps
`default_nettype none

module daq_frame_mux
(
	input  wire                                 usr_clk_wordwise,
	input  wire                                 arst,
	input  wire                                 word_rst_i,
	input  wire [daq_tx_pkg::WORD_W-1:0]        txd_i,
	input  wire                                 txd_vld_i,
	input  wire daq_tx_pkg::rom_addr_t          rom_addr_i,
	input  wire                                 crc_dv_i,
	input  wire                                 clr_crc_i,
	daq_crc_if.pipe                             crc_if,
	output logic [daq_tx_pkg::WORD_W-1:0]       tx_data_o,
	output logic [daq_tx_pkg::K_W-1:0]          tx_k_o,
	output logic [daq_tx_pkg::PKT_LEN_W-1:0]    pkt_len_o
);
	import daq_tx_pkg::*;

	logic                 crc_calc;
	tx_word_u             rom_word;
	logic [K_W-1:0]       rom_k;
	logic [WORD_W-1:0]    data_d1;
	logic                 crc_calc_d1;
	logic                 vld_d1;
	logic                 crc_lo_sel;	// Low CRC half into output reg
	logic                 crc_hi_sel;
	tx_word_u             out_word;
	logic [K_W-1:0]       out_k;
	logic [PKT_LEN_W-1:0] len_cnt;

	assign crc_calc    = crc_dv_i & txd_vld_i;
	assign crc_if.init = clr_crc_i;
	assign crc_if.calc = crc_calc;
	assign crc_if.data = txd_i;

	////////////////////////////////////////
	// Frame ROM and K flag ROM
	////////////////////////////////////////
	always_ff @(posedge usr_clk_wordwise)
	begin
		case (rom_addr_i)
			ROM_SOP:
			begin
				rom_word.oct.hi_oct <= PRMBL;
				rom_word.oct.lo_oct <= K27_7;
				rom_k               <= 2'b01;
			end
			ROM_PRE:
			begin
				rom_word.oct.hi_oct <= PRMBL;
				rom_word.oct.lo_oct <= PRMBL;
				rom_k               <= 2'b00;
			end
			ROM_SOF:
			begin
				rom_word.oct.hi_oct <= SOF_BYTE;
				rom_word.oct.lo_oct <= PRMBL;
				rom_k               <= 2'b00;
			end
			ROM_FILL:
			begin
				rom_word.word <= '0;	// Replaced by data or CRC
				rom_k         <= 2'b00;
			end
			ROM_EOP:
			begin
				rom_word.oct.hi_oct <= K23_7;
				rom_word.oct.lo_oct <= K29_7;
				rom_k               <= 2'b11;
			end
			ROM_EXT:
			begin
				rom_word.oct.hi_oct <= K23_7;
				rom_word.oct.lo_oct <= K23_7;
				rom_k               <= 2'b11;
			end
			default:
			begin
				rom_word.oct.hi_oct <= D16_2;	// Idle /I2/
				rom_word.oct.lo_oct <= K28_5;
				rom_k               <= 2'b01;
			end
		endcase
	end

	// Data path delay to line up with the ROM
	always_ff @(posedge usr_clk_wordwise)
	begin
		data_d1 <= txd_i;
	end

	always_ff @(posedge usr_clk_wordwise or posedge arst)
	begin
		if (arst)
		begin
			vld_d1      <= 1'b0;
			crc_calc_d1 <= 1'b0;
			crc_lo_sel  <= 1'b0;
			crc_hi_sel  <= 1'b0;
		end
		else
		begin
			vld_d1      <= txd_vld_i;
			crc_calc_d1 <= crc_calc;
			crc_lo_sel  <= crc_dv_i & vld_d1 & ~txd_vld_i;	// Trailing edge of valid
			crc_hi_sel  <= crc_lo_sel;
		end
	end

	////////////////////////////////////////
	// Output register
	////////////////////////////////////////
	always_ff @(posedge usr_clk_wordwise or posedge arst)
	begin
		if (arst)
		begin
			out_word.word <= IDLE2;
			out_k         <= 2'b01;
		end
		else if (word_rst_i)
		begin
			out_word.word <= IDLE2;	// Idles until the link is up
			out_k         <= 2'b01;
		end
		else
		begin
			out_k <= rom_k;
			if (crc_lo_sel)
				out_word.word <= crc_if.crc[WORD_W-1:0];
			else if (crc_hi_sel)
				out_word.word <= crc_if.crc[2*WORD_W-1:WORD_W];
			else if (crc_calc_d1)
				out_word.word <= data_d1;
			else
				out_word.word <= rom_word.word;
		end
	end

	assign tx_data_o = out_word.word;
	assign tx_k_o    = out_k;

	// Packet length, captured as the low CRC half is loaded
	always_ff @(posedge usr_clk_wordwise or posedge arst)
	begin
		if (arst)
		begin
			len_cnt   <= '0;
			pkt_len_o <= PKT_LEN_RST;
		end
		else
		begin
			if (clr_crc_i)
				len_cnt <= '0;
			else if (crc_calc)
				len_cnt <= len_cnt + 1'b1;
			if (crc_lo_sel)
				pkt_len_o <= len_cnt;
		end
	end

endmodule

`default_nettype wire

/* daq_tx_top.sv */
`timescale 1ns/1ps
`default_nettype none

module daq_tx_top #(
	parameter int IPG_WORDS  = 6,
	parameter int RST_STAGES = 4
)
(
	input  wire                                 usr_clk_wordwise,
	input  wire                                 arst,
	input  wire                                 pll_lock_i,
	input  wire [daq_tx_pkg::WORD_W-1:0]        txd_i,
	input  wire                                 txd_vld_i,
	output logic                                tx_ack_o,
	output logic [daq_tx_pkg::WORD_W-1:0]       tx_data_o,
	output logic [daq_tx_pkg::K_W-1:0]          tx_k_o,
	output logic [daq_tx_pkg::PKT_LEN_W-1:0]    pkt_len_o
);
	import daq_tx_pkg::*;

	logic      word_rst;	// Held until the TX PLL locks
	rom_addr_t rom_addr;
	logic      crc_dv;
	logic      clr_crc;

	daq_crc_if crc_bus ();

	daq_rst_sync #(
		.RST_STAGES (RST_STAGES)
	)
	rst_sync_i
	(
		.usr_clk_wordwise (usr_clk_wordwise),
		.arst             (arst),
		.pll_lock_i       (pll_lock_i),
		.word_rst_o       (word_rst)
	);

	daq_frame_fsm #(
		.IPG_WORDS (IPG_WORDS)
	)
	frame_fsm_i
	(
		.usr_clk_wordwise (usr_clk_wordwise),
		.arst             (arst),
		.word_rst_i       (word_rst),
		.txd_vld_i        (txd_vld_i),
		.tx_ack_o         (tx_ack_o),
		.rom_addr_o       (rom_addr),
		.crc_dv_o         (crc_dv),
		.clr_crc_o        (clr_crc)
	);

	daq_frame_mux frame_mux_i
	(
		.usr_clk_wordwise (usr_clk_wordwise),
		.arst             (arst),
		.word_rst_i       (word_rst),
		.txd_i            (txd_i),
		.txd_vld_i        (txd_vld_i),
		.rom_addr_i       (rom_addr),
		.crc_dv_i         (crc_dv),
		.clr_crc_i        (clr_crc),
		.crc_if           (crc_bus.pipe),
		.tx_data_o        (tx_data_o),
		.tx_k_o           (tx_k_o),
		.pkt_len_o        (pkt_len_o)
	);

	daq_crc32 crc32_i
	(
		.usr_clk_wordwise (usr_clk_wordwise),
		.arst             (arst),
		.crc_if           (crc_bus.engine)
	);

endmodule

`default_nettype wire

/* tb_daq_tx.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_daq_tx;
	import daq_tx_pkg::*;

	localparam int IPG_WORDS = 6;
	localparam int MAX_PKTS  = 32;
	localparam int LEN_RST   = 800;	// pkt_len_o before any packet

	logic                 usr_clk_wordwise;
	logic                 arst;
	logic                 pll_lock;
	logic [WORD_W-1:0]    txd;
	logic                 txd_vld;
	wire                  tx_ack;
	wire [WORD_W-1:0]     tx_data;
	wire [K_W-1:0]        tx_k;
	wire [PKT_LEN_W-1:0]  pkt_len;

	logic [15:0]          stim_mem [0:2*MAX_PKTS-1];	// Length, first word
	int                   n_pkts;
	int                   limit_cycles;
	bit                   stim_ready;
	int                   mismatch_cnt;
	int                   fail_cnt;
	int                   ack_cnt;
	bit                   in_frame;
	logic [WORD_W-1:0]    exp_word [$];
	logic [K_W-1:0]       exp_k [$];
	int                   exp_tag [$];	// 1 first CRC word, 2 last word of frame
	int                   exp_len [$];

	daq_tx_top #(
		.IPG_WORDS  (IPG_WORDS),
		.RST_STAGES (4)
	)
	dut_i
	(
		.usr_clk_wordwise (usr_clk_wordwise),
		.arst             (arst),
		.pll_lock_i       (pll_lock),
		.txd_i            (txd),
		.txd_vld_i        (txd_vld),
		.tx_ack_o         (tx_ack),
		.tx_data_o        (tx_data),
		.tx_k_o           (tx_k),
		.pkt_len_o        (pkt_len)
	);

	initial usr_clk_wordwise = 1'b0;
	always #50 usr_clk_wordwise = ~usr_clk_wordwise;	// 100 ns word clock

	////////////////////////////////////////
	// Reference model
	////////////////////////////////////////
	// Ethernet FCS, byte at a time, low octet of each word first
	function automatic logic [31:0] fcs_of_words(input logic [WORD_W-1:0] first, input int len);
		logic [31:0]       c;
		logic [WORD_W-1:0] wd;
		logic [7:0]        b;
		c = 32'hFFFFFFFF;
		for (int w = 0; w < len; w++)
		begin
			wd = WORD_W'(first + w);
			for (int o = 0; o < 2; o++)
			begin
				b = (o == 0) ? wd[7:0] : wd[15:8];
				c = c ^ {24'h0, b};
				for (int j = 0; j < 8; j++)
					c = c[0] ? ((c >> 1) ^ 32'hEDB88320) : (c >> 1);
			end
		end
		return ~c;
	endfunction

	task automatic push_word(input logic [WORD_W-1:0] w, input logic [K_W-1:0] k, input int tag);
		exp_word.push_back(w);
		exp_k.push_back(k);
		exp_tag.push_back(tag);
	endtask

	task automatic queue_frame(input logic [WORD_W-1:0] first, input int len);
		logic [31:0] fcs;
		fcs = fcs_of_words(first, len);
		push_word(SOP_PRE, 2'b01, 0);
		push_word(PREAMBLE, 2'b00, 0);
		push_word(PREAMBLE, 2'b00, 0);
		push_word(SOF_PRE, 2'b00, 0);
		for (int n = 0; n < len; n++)
			push_word(WORD_W'(first + n), 2'b00, 0);
		push_word(fcs[15:0], 2'b00, 1);	// Low half first
		push_word(fcs[31:16], 2'b00, 0);
		push_word(EOP_EXT, 2'b11, 0);
		push_word(CAR_EXT, 2'b11, 2);
		exp_len.push_back(len);
	endtask

	////////////////////////////////////////
	// Output monitor
	////////////////////////////////////////
	task automatic check_next_word();
		logic [WORD_W-1:0] w;
		logic [K_W-1:0]    k;
		int                tag;
		int                len;
		w        = exp_word.pop_front();
		k        = exp_k.pop_front();
		tag      = exp_tag.pop_front();
		in_frame = (tag != 2);
		assert (tx_data == w && tx_k == k)
		else
		begin
			mismatch_cnt++;
			$display("MISMATCH at %0t: word %h k %b, expected %h k %b",
				$time, tx_data, tx_k, w, k);
		end
		if (tag == 1)
		begin
			len = exp_len.pop_front();
			assert (pkt_len == PKT_LEN_W'(len))
			else
			begin
				mismatch_cnt++;
				$display("MISMATCH at %0t: pkt_len_o %0d, expected %0d", $time, pkt_len, len);
			end
		end
	endtask

	always @(negedge usr_clk_wordwise)
	begin
		if (tx_ack)
			ack_cnt++;
		if (!in_frame && exp_word.size() == 0)
		begin
			assert (tx_data == IDLE2 && tx_k == 2'b01)
			else
			begin
				mismatch_cnt++;
				$display("MISMATCH at %0t: word %h k %b, expected idle", $time, tx_data, tx_k);
			end
		end
		else if (in_frame || tx_data != IDLE2 || tx_k != 2'b01)
			check_next_word();	// Frame under way or starting
	end

	// Quiet link, no ack and no captured length yet
	task automatic check_quiet();
		assert (!tx_ack)
		else
		begin
			mismatch_cnt++;
			$display("MISMATCH at %0t: tx_ack_o high on a quiet link", $time);
		end
		assert (pkt_len == PKT_LEN_W'(LEN_RST))
		else
		begin
			mismatch_cnt++;
			$display("MISMATCH at %0t: pkt_len_o %0d, expected %0d", $time, pkt_len, LEN_RST);
		end
	endtask

	task automatic wait_ack(input int pkt);
		int cycles;
		cycles = 0;
		do
		begin
			@(negedge usr_clk_wordwise);
			cycles++;
		end
		while (!tx_ack && cycles < 16);
		assert (tx_ack)
		else
		begin
			fail_cnt++;
			$display("No tx_ack_o within 16 cycles for packet %0d", pkt);
		end
	endtask

	////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////
	initial
	begin
		int                seed;
		int                gap;
		int                len;
		logic [WORD_W-1:0] first;
		seed     = 91273;
		void'($urandom(seed));
		arst     = 1'b1;
		pll_lock = 1'b0;
		txd      = '0;
		txd_vld  = 1'b0;
		$readmemh("daq_tx_input.txt", stim_mem);
		n_pkts = 0;
		while (n_pkts < MAX_PKTS && !$isunknown(stim_mem[2*n_pkts]))
			n_pkts++;
		limit_cycles = 100;
		for (int i = 0; i < n_pkts; i++)
			limit_cycles += int'(stim_mem[2*i]) + 30;
		stim_ready = 1'b1;
		assert (n_pkts > 0)
		else
		begin
			fail_cnt++;
			$display("No packets could be read from daq_tx_input.txt");
		end

		repeat (4) @(negedge usr_clk_wordwise);
		arst = 1'b0;
		for (int i = 0; i < 12; i++)
		begin
			@(negedge usr_clk_wordwise);
			check_quiet();
			txd_vld = (i >= 3 && i < 7);	// Request while unlocked is ignored
		end
		pll_lock = 1'b1;
		for (int i = 0; i < 10; i++)
		begin
			@(negedge usr_clk_wordwise);
			check_quiet();
		end

		for (int p = 0; p < n_pkts; p++)
		begin
			len   = stim_mem[2*p];
			first = stim_mem[2*p+1];
			queue_frame(first, len);
			txd_vld = 1'b1;
			wait_ack(p);
			for (int n = 0; n < len; n++)
			begin
				@(negedge usr_clk_wordwise);
				assert (!tx_ack)
				else
				begin
					mismatch_cnt++;
					$display("MISMATCH at %0t: second tx_ack_o in packet %0d", $time, p);
				end
				txd = WORD_W'(first + n);
			end
			@(negedge usr_clk_wordwise);
			txd_vld = 1'b0;
			txd     = '0;
			gap     = IPG_WORDS + 4 + int'($urandom % 8);
			repeat (gap) @(negedge usr_clk_wordwise);
		end

		repeat (8) @(negedge usr_clk_wordwise);
		assert (exp_word.size() == 0)
		else
		begin
			fail_cnt++;
			$display("%0d expected frame words never reached the output", exp_word.size());
		end
		assert (ack_cnt == n_pkts)
		else
		begin
			fail_cnt++;
			$display("Counted %0d acknowledges for %0d packets", ack_cnt, n_pkts);
		end
		$display("Errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
		if (mismatch_cnt + fail_cnt == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

	// Watchdog, budget scales with total packet length
	initial
	begin
		wait (stim_ready);
		repeat (limit_cycles) @(posedge usr_clk_wordwise);
		$display("Watchdog expired after %0d cycles, the run did not complete", limit_cycles);
		$display("FAIL: see errors above");
		$finish;
	end

endmodule

`default_nettype wire

/* all.f */
daq_tx_pkg.sv
daq_crc_if.sv
daq_rst_sync.sv
daq_crc32.sv
daq_frame_fsm.sv
daq_frame_mux.sv
daq_tx_top.sv
tb_daq_tx.sv

/* daq_tx_input.txt */
// One packet per line
// Columns: length in words (hex), first data word (hex)
0001 0000
0002 FFFF
0005 50BC
0010 1234
0003 55D5
0020 A000
0008 FB55
0001 8000
0040 0100
0004 FFFE
000C C3C3
0007 0F0F
0011 7FF0
0002 D555
0019 BEEF
0006 0001
